// File: include/sine_table.svh
// one period of a sine, offset to mid-scale.
localparam logic [7:0] sine_table [64] = '{
    8'd128, 8'd140, 8'd153, 8'd165, 8'd177, 8'd188, 8'd199, 8'd209,
    8'd218, 8'd226, 8'd234, 8'd240, 8'd245, 8'd250, 8'd253, 8'd254,
    8'd255, 8'd254, 8'd253, 8'd250, 8'd245, 8'd240, 8'd234, 8'd226,
    8'd218, 8'd209, 8'd199, 8'd188, 8'd177, 8'd165, 8'd153, 8'd140,
    8'd128, 8'd116, 8'd103, 8'd91, 8'd79, 8'd68, 8'd57, 8'd47,
    8'd38, 8'd30, 8'd22, 8'd16, 8'd11, 8'd6, 8'd3, 8'd2,
    8'd1, 8'd2, 8'd3, 8'd6, 8'd11, 8'd16, 8'd22, 8'd30,
    8'd38, 8'd47, 8'd57, 8'd68, 8'd79, 8'd91, 8'd103, 8'd116
};

// File: src/wavegen_pkg.sv
package wavegen_pkg;

    localparam int N_CHANNELS = 4;
    localparam int N_PARAMS = 3;

    typedef logic [15:0] sample_t;
    typedef logic [15:0] param_t;
    typedef logic [15:0] phase_t;
    typedef logic [1:0] channel_t;
    typedef logic [7:0] reg_addr_t;
    typedef logic [31:0] bus_data_t;

    typedef enum logic [1:0] {
        SHAPE_SQUARE = 2'd0,
        SHAPE_TRIANGLE = 2'd1,
        SHAPE_SINE = 2'd2
    } shape_t;  // code 3 falls back to square.

    localparam reg_addr_t REG_CHANNEL_COUNT = 8'h00;
    localparam reg_addr_t REG_SHAPE = 8'h04;  // write also fires the latch.
    localparam reg_addr_t REG_CHANNEL_SELECT = 8'h08;
    localparam reg_addr_t REG_PERIOD = 8'h0C;
    localparam reg_addr_t REG_AMPLITUDE = 8'h10;
    localparam reg_addr_t REG_AUX = 8'h14;  // duty or slope.

    localparam int PARAM_PERIOD = 0;  // slots of the staged set.
    localparam int PARAM_AMPLITUDE = 1;
    localparam int PARAM_AUX = 2;

    // phase after one step, wrapping after period - 1, with period 0 acting as 1
    function automatic phase_t next_phase(phase_t phase, param_t period);
        return (period <= param_t'(1) || phase >= period - param_t'(1)) ? '0 : phase + 1'b1;
    endfunction

endpackage

// File: src/axil_register_unit.sv
`timescale 1ns/1ps

module axil_register_unit (
    input  logic clock,
    input  logic reset,
    input  wavegen_pkg::reg_addr_t awaddr,
    input  logic awvalid,
    output logic awready,
    input  wavegen_pkg::bus_data_t wdata,
    input  logic wvalid,
    output logic wready,
    output logic bvalid,
    input  logic bready,
    input  wavegen_pkg::reg_addr_t araddr,
    input  logic arvalid,
    output logic arready,
    output wavegen_pkg::bus_data_t rdata,
    output logic rvalid,
    input  logic rready,
    output logic [wavegen_pkg::N_CHANNELS-1:0] channel_enable,
    output wavegen_pkg::shape_t shape,
    output wavegen_pkg::param_t [wavegen_pkg::N_CHANNELS-1:0] period,
    output wavegen_pkg::param_t [wavegen_pkg::N_CHANNELS-1:0] amplitude,
    output wavegen_pkg::param_t [wavegen_pkg::N_CHANNELS-1:0] aux,
    output logic configured
);

    wavegen_pkg::bus_data_t channel_count;
    wavegen_pkg::channel_t channel_select;
    wavegen_pkg::param_t [wavegen_pkg::N_PARAMS-1:0] staged;
    wavegen_pkg::bus_data_t read_value;
    logic write_accept;
    logic read_accept;
    logic latch;

    assign write_accept = awready & awvalid & wvalid;
    assign read_accept = arready & arvalid;

    always_ff @(posedge clock) begin
        if (reset) begin
            awready <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
            arready <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            awready <= awvalid & wvalid & ~awready & ~bvalid;  // one-cycle pulse.
            wready <= awvalid & wvalid & ~awready & ~bvalid;
            if (write_accept) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            arready <= arvalid & ~arready & ~rvalid;
            if (read_accept) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            channel_count <= '0;
            shape <= wavegen_pkg::SHAPE_SQUARE;
            channel_select <= '0;
            staged <= '0;
            latch <= 1'b0;
        end else begin
            latch <= write_accept && awaddr == wavegen_pkg::REG_SHAPE;
            if (write_accept) begin
                case (awaddr)
                    wavegen_pkg::REG_CHANNEL_COUNT: channel_count <= wdata;
                    wavegen_pkg::REG_SHAPE: shape <= wavegen_pkg::shape_t'(wdata[1:0]);
                    wavegen_pkg::REG_CHANNEL_SELECT: channel_select <= wdata[1:0];
                    wavegen_pkg::REG_PERIOD: staged[wavegen_pkg::PARAM_PERIOD] <= wdata[15:0];
                    wavegen_pkg::REG_AMPLITUDE: staged[wavegen_pkg::PARAM_AMPLITUDE] <= wdata[15:0];
                    wavegen_pkg::REG_AUX: staged[wavegen_pkg::PARAM_AUX] <= wdata[15:0];
                    default: ;  // unmapped, dropped.
                endcase
            end
        end
    end

    // staged set lands in the selected channel the cycle after the shape write
    always_ff @(posedge clock) begin
        if (reset) begin
            period <= '0;
            amplitude <= '0;
            aux <= '0;
            configured <= 1'b0;
        end else if (latch) begin
            period[channel_select] <= staged[wavegen_pkg::PARAM_PERIOD];
            amplitude[channel_select] <= staged[wavegen_pkg::PARAM_AMPLITUDE];
            aux[channel_select] <= staged[wavegen_pkg::PARAM_AUX];
            configured <= 1'b1;  // sticky until reset.
        end
    end

    always_comb begin
        for (int ch = 0; ch < wavegen_pkg::N_CHANNELS; ch++) begin
            channel_enable[ch] = channel_count > wavegen_pkg::bus_data_t'(ch);
        end
    end

    always_comb begin
        case (araddr)
            wavegen_pkg::REG_CHANNEL_COUNT: read_value = channel_count;
            wavegen_pkg::REG_SHAPE: read_value = 32'(shape);
            wavegen_pkg::REG_CHANNEL_SELECT: read_value = 32'(channel_select);
            wavegen_pkg::REG_PERIOD: read_value = 32'(staged[wavegen_pkg::PARAM_PERIOD]);
            wavegen_pkg::REG_AMPLITUDE: read_value = 32'(staged[wavegen_pkg::PARAM_AMPLITUDE]);
            wavegen_pkg::REG_AUX: read_value = 32'(staged[wavegen_pkg::PARAM_AUX]);
            default: read_value = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (read_accept) begin
            rdata <= read_value;
        end
    end

endmodule

// File: src/square_core.sv
`timescale 1ns/1ps

module square_core (
    input  logic clock,
    input  logic reset,
    input  logic trigger,
    input  logic enable,
    input  wavegen_pkg::param_t period,
    input  wavegen_pkg::param_t amplitude,
    input  wavegen_pkg::param_t aux,
    output wavegen_pkg::sample_t sample,
    output logic valid,
    input  logic ready
);

    wavegen_pkg::phase_t phase;
    logic step;

    assign step = trigger & enable & ~valid;  // only with the slot empty.

    always_ff @(posedge clock) begin
        if (reset) begin
            phase <= '0;
            valid <= 1'b0;
        end else if (step) begin
            phase <= wavegen_pkg::next_phase(phase, period);
            valid <= 1'b1;
        end else if (ready) begin
            valid <= 1'b0;  // popped.
        end
    end

    always_ff @(posedge clock) begin
        if (step) begin
            sample <= (phase < aux) ? amplitude : '0;  // high part of the duty.
        end
    end

endmodule

// File: src/triangle_core.sv
`timescale 1ns/1ps

module triangle_core (
    input  logic clock,
    input  logic reset,
    input  logic trigger,
    input  logic enable,
    input  wavegen_pkg::param_t period,
    input  wavegen_pkg::param_t amplitude,
    input  wavegen_pkg::param_t aux,
    output wavegen_pkg::sample_t sample,
    output logic valid,
    input  logic ready
);

    wavegen_pkg::phase_t phase;
    wavegen_pkg::phase_t remaining;
    wavegen_pkg::phase_t distance;
    logic step;

    assign step = trigger & enable & ~valid;
    assign remaining = period - phase;
    assign distance = (phase < remaining) ? phase : remaining;  // distance to nearest end.

    always_ff @(posedge clock) begin
        if (reset) begin
            phase <= '0;
            valid <= 1'b0;
        end else if (step) begin
            phase <= wavegen_pkg::next_phase(phase, period);
            valid <= 1'b1;
        end else if (ready) begin
            valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (step) begin
            sample <= wavegen_pkg::sample_t'(aux * distance);  // slope times distance, wraps.
        end
    end

endmodule

// File: src/sine_core.sv
`timescale 1ns/1ps

module sine_core (
    input  logic clock,
    input  logic reset,
    input  logic trigger,
    input  logic enable,
    input  wavegen_pkg::param_t period,
    input  wavegen_pkg::param_t amplitude,
    output wavegen_pkg::sample_t sample,
    output logic valid,
    input  logic ready
);

`include "sine_table.svh"

    wavegen_pkg::phase_t phase;
    logic [23:0] scaled;
    logic step;

    assign step = trigger & enable & ~valid;
    assign scaled = sine_table[phase[5:0]] * amplitude;  // table repeats every 64 steps.

    always_ff @(posedge clock) begin
        if (reset) begin
            phase <= '0;
            valid <= 1'b0;
        end else if (step) begin
            phase <= wavegen_pkg::next_phase(phase, period);
            valid <= 1'b1;
        end else if (ready) begin
            valid <= 1'b0;
        end
    end

    // 8-bit table times amplitude, back down to sample scale
    always_ff @(posedge clock) begin
        if (step) begin
            sample <= scaled[23:8];
        end
    end

endmodule

// File: src/sample_serializer.sv
`timescale 1ns/1ps

module sample_serializer (
    input  logic clock,
    input  logic reset,
    input  wavegen_pkg::shape_t shape,
    input  logic [wavegen_pkg::N_CHANNELS-1:0] channel_enable,
    input  wavegen_pkg::sample_t [wavegen_pkg::N_CHANNELS-1:0] square_sample,
    input  wavegen_pkg::sample_t [wavegen_pkg::N_CHANNELS-1:0] triangle_sample,
    input  wavegen_pkg::sample_t [wavegen_pkg::N_CHANNELS-1:0] sine_sample,
    input  logic [wavegen_pkg::N_CHANNELS-1:0] core_valid,
    output logic [wavegen_pkg::N_CHANNELS-1:0] core_ready,
    output wavegen_pkg::sample_t out_sample,
    output wavegen_pkg::channel_t out_channel,
    output logic out_valid,
    output logic out_last,
    input  logic out_ready
);

    typedef enum logic {
        IDLE,
        SEND
    } state_t;

    state_t state;
    wavegen_pkg::channel_t pointer;
    wavegen_pkg::channel_t current;
    wavegen_pkg::sample_t selected;
    logic take;
    logic is_last;

    assign current = (state == IDLE) ? '0 : pointer;  // burst always opens on channel 0.
    assign take = core_valid[current] & (~out_valid | out_ready);

    always_comb begin
        case (shape)
            wavegen_pkg::SHAPE_TRIANGLE: selected = triangle_sample[current];
            wavegen_pkg::SHAPE_SINE: selected = sine_sample[current];
            default: selected = square_sample[current];
        endcase
    end

    always_comb begin
        if (int'(current) == wavegen_pkg::N_CHANNELS - 1) begin
            is_last = 1'b1;
        end else begin
            is_last = ~channel_enable[current + 2'd1];  // next channel is off.
        end
    end

    // pop all three cores of the channel so they stay in step
    always_comb begin
        core_ready = '0;
        core_ready[current] = take;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= IDLE;
            pointer <= '0;
            out_valid <= 1'b0;
            out_last <= 1'b0;
        end else if (take) begin
            out_valid <= 1'b1;
            out_last <= is_last;
            state <= is_last ? IDLE : SEND;
            pointer <= is_last ? '0 : current + 2'd1;
        end else if (out_ready) begin
            out_valid <= 1'b0;  // drained, nothing new.
            out_last <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            out_sample <= selected;
            out_channel <= current;
        end
    end

endmodule

// File: src/waveform_generator.sv
`timescale 1ns/1ps

module waveform_generator (
    input  logic clock,
    input  logic reset,
    input  logic trigger,
    input  wavegen_pkg::reg_addr_t awaddr,
    input  logic awvalid,
    output logic awready,
    input  wavegen_pkg::bus_data_t wdata,
    input  logic wvalid,
    output logic wready,
    output logic bvalid,
    input  logic bready,
    input  wavegen_pkg::reg_addr_t araddr,
    input  logic arvalid,
    output logic arready,
    output wavegen_pkg::bus_data_t rdata,
    output logic rvalid,
    input  logic rready,
    output logic configured,
    output wavegen_pkg::sample_t out_sample,
    output wavegen_pkg::channel_t out_channel,
    output logic out_valid,
    output logic out_last,
    input  logic out_ready
);

    logic [wavegen_pkg::N_CHANNELS-1:0] channel_enable;
    wavegen_pkg::shape_t shape;
    wavegen_pkg::param_t [wavegen_pkg::N_CHANNELS-1:0] period;
    wavegen_pkg::param_t [wavegen_pkg::N_CHANNELS-1:0] amplitude;
    wavegen_pkg::param_t [wavegen_pkg::N_CHANNELS-1:0] aux;
    wavegen_pkg::sample_t [wavegen_pkg::N_CHANNELS-1:0] square_sample;
    wavegen_pkg::sample_t [wavegen_pkg::N_CHANNELS-1:0] triangle_sample;
    wavegen_pkg::sample_t [wavegen_pkg::N_CHANNELS-1:0] sine_sample;
    logic [wavegen_pkg::N_CHANNELS-1:0] square_valid;
    logic [wavegen_pkg::N_CHANNELS-1:0] triangle_valid;
    logic [wavegen_pkg::N_CHANNELS-1:0] sine_valid;
    logic [wavegen_pkg::N_CHANNELS-1:0] core_ready;
    logic cores_busy;

    // channels step together, so no core takes a trigger until the burst drains
    assign cores_busy = |{square_valid, triangle_valid, sine_valid};

    axil_register_unit registers0 (
        .clock(clock), .reset(reset),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rvalid(rvalid), .rready(rready),
        .channel_enable(channel_enable), .shape(shape),
        .period(period), .amplitude(amplitude), .aux(aux),
        .configured(configured)
    );

    for (genvar ch = 0; ch < wavegen_pkg::N_CHANNELS; ch++) begin : g_channel
        square_core square0 (
            .clock(clock), .reset(reset), .trigger(trigger),
            .enable(channel_enable[ch] & ~cores_busy),
            .period(period[ch]), .amplitude(amplitude[ch]), .aux(aux[ch]),
            .sample(square_sample[ch]), .valid(square_valid[ch]), .ready(core_ready[ch])
        );

        triangle_core triangle0 (
            .clock(clock), .reset(reset), .trigger(trigger),
            .enable(channel_enable[ch] & ~cores_busy),
            .period(period[ch]), .amplitude(amplitude[ch]), .aux(aux[ch]),
            .sample(triangle_sample[ch]), .valid(triangle_valid[ch]), .ready(core_ready[ch])
        );

        sine_core sine0 (
            .clock(clock), .reset(reset), .trigger(trigger),
            .enable(channel_enable[ch] & ~cores_busy),
            .period(period[ch]), .amplitude(amplitude[ch]),
            .sample(sine_sample[ch]), .valid(sine_valid[ch]), .ready(core_ready[ch])
        );
    end

    sample_serializer serializer0 (
        .clock(clock), .reset(reset),
        .shape(shape), .channel_enable(channel_enable),
        .square_sample(square_sample), .triangle_sample(triangle_sample),
        .sine_sample(sine_sample),
        .core_valid(square_valid), .core_ready(core_ready),  // square valid speaks for the channel.
        .out_sample(out_sample), .out_channel(out_channel),
        .out_valid(out_valid), .out_last(out_last), .out_ready(out_ready)
    );

endmodule

// File: verif/waveform_generator_tb.sv
`timescale 1ns/1ps

module waveform_generator_tb;

`include "sine_table.svh"

    localparam int TIMEOUT_CYCLES = 3000;  // about twice the whole run.

    logic clock;
    logic reset;
    logic trigger;
    wavegen_pkg::reg_addr_t awaddr;
    logic awvalid;
    logic awready;
    wavegen_pkg::bus_data_t wdata;
    logic wvalid;
    logic wready;
    logic bvalid;
    logic bready;
    wavegen_pkg::reg_addr_t araddr;
    logic arvalid;
    logic arready;
    wavegen_pkg::bus_data_t rdata;
    logic rvalid;
    logic rready;
    logic configured;
    wavegen_pkg::sample_t out_sample;
    wavegen_pkg::channel_t out_channel;
    logic out_valid;
    logic out_last;
    logic out_ready;

    integer seed;
    logic [31:0] rnd;
    logic random_ready = 1'b0;
    int cycle_count = 0;

    wavegen_pkg::sample_t exp_sample[$];  // beats still owed by the DUT.
    wavegen_pkg::channel_t exp_channel[$];
    logic exp_last[$];

    wavegen_pkg::bus_data_t model_count = '0;
    wavegen_pkg::bus_data_t model_shape = '0;
    wavegen_pkg::bus_data_t model_select = '0;
    wavegen_pkg::bus_data_t staged_period = '0;
    wavegen_pkg::bus_data_t staged_amplitude = '0;
    wavegen_pkg::bus_data_t staged_aux = '0;
    wavegen_pkg::param_t model_period [wavegen_pkg::N_CHANNELS] = '{default: '0};
    wavegen_pkg::param_t model_amplitude [wavegen_pkg::N_CHANNELS] = '{default: '0};
    wavegen_pkg::param_t model_aux [wavegen_pkg::N_CHANNELS] = '{default: '0};
    wavegen_pkg::phase_t model_phase [wavegen_pkg::N_CHANNELS] = '{default: '0};

    logic hold_pending = 1'b0;
    wavegen_pkg::sample_t held_sample;
    wavegen_pkg::channel_t held_channel;
    logic held_last;

    waveform_generator dut0 (
        .clock(clock), .reset(reset), .trigger(trigger),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rvalid(rvalid), .rready(rready),
        .configured(configured),
        .out_sample(out_sample), .out_channel(out_channel),
        .out_valid(out_valid), .out_last(out_last), .out_ready(out_ready)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #5 clock = ~clock;
        end
    end

    // sink backpressure that is random only while enabled
    initial begin
        seed = 32'he3e574e2;
        out_ready = 1'b1;
        forever begin
            @(posedge clock);
            #1;
            rnd = $random(seed);
            out_ready = random_ready ? rnd[0] : 1'b1;
        end
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            show_failure("the run did not finish within the cycle limit");
            $fatal(1, "timeout");
        end
    end

    task automatic show_error(string name, logic [31:0] expected, logic [31:0] actual);
        $display("** Error at %0t: %s expected 0x%0h, actual 0x%0h",
                 $time, name, expected, actual);
        $display("Test failures found");
    endtask

    task automatic show_failure(string what);
        $display("%s at %0t", what, $time);
        $display("Test failures found");
    endtask

    task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
        assert (actual == expected) else begin
            show_error(name, expected, actual);
            $fatal(1, "value check");
        end
    endtask

    // sample of one channel at its current model phase
    function automatic wavegen_pkg::sample_t expected_sample(int ch);
        wavegen_pkg::phase_t p;
        wavegen_pkg::phase_t rest;
        logic [31:0] product;
        p = model_phase[ch];
        case (model_shape)
            32'd1: begin
                rest = model_period[ch] - p;
                product = 32'(model_aux[ch]) * 32'((p < rest) ? p : rest);
                return wavegen_pkg::sample_t'(product);  // keeps the low 16 bits.
            end
            32'd2: begin
                product = 32'(sine_table[int'(p) % 64]) * 32'(model_amplitude[ch]);
                return wavegen_pkg::sample_t'(product >> 8);
            end
            default: return (p < model_aux[ch]) ? model_amplitude[ch] : '0;
        endcase
    endfunction

    task automatic advance_phase(int ch);
        if (model_period[ch] == 0 || int'(model_phase[ch]) + 1 >= int'(model_period[ch])) begin
            model_phase[ch] = '0;  // period 0 acts as 1.
        end else begin
            model_phase[ch] = model_phase[ch] + 16'd1;
        end
    endtask

    task automatic write_reg(wavegen_pkg::reg_addr_t addr, wavegen_pkg::bus_data_t data);
        int sel;
        @(posedge clock);
        #1;
        awaddr = addr;
        wdata = data;
        awvalid = 1'b1;
        wvalid = 1'b1;
        do @(negedge clock); while (!awready);
        check_value("wready", 32'(wready), 32'd1);
        @(posedge clock);
        #1;
        awvalid = 1'b0;
        wvalid = 1'b0;
        do @(negedge clock); while (!bvalid);
        sel = int'(model_select);
        case (addr)
            wavegen_pkg::REG_CHANNEL_COUNT: model_count = data;
            wavegen_pkg::REG_SHAPE: begin
                model_shape = data & 32'h3;
                model_period[sel] = wavegen_pkg::param_t'(staged_period);  // latch fires.
                model_amplitude[sel] = wavegen_pkg::param_t'(staged_amplitude);
                model_aux[sel] = wavegen_pkg::param_t'(staged_aux);
            end
            wavegen_pkg::REG_CHANNEL_SELECT: model_select = data & 32'h3;
            wavegen_pkg::REG_PERIOD: staged_period = data & 32'hffff;
            wavegen_pkg::REG_AMPLITUDE: staged_amplitude = data & 32'hffff;
            wavegen_pkg::REG_AUX: staged_aux = data & 32'hffff;
            default: ;
        endcase
    endtask

    task automatic read_check(wavegen_pkg::reg_addr_t addr, wavegen_pkg::bus_data_t expected);
        @(posedge clock);
        #1;
        araddr = addr;
        arvalid = 1'b1;
        do @(negedge clock); while (!arready);
        @(posedge clock);
        #1;
        arvalid = 1'b0;
        do @(negedge clock); while (!rvalid);
        check_value("rdata", rdata, expected);
    endtask

    task automatic read_all_registers();
        read_check(wavegen_pkg::REG_CHANNEL_COUNT, model_count);
        read_check(wavegen_pkg::REG_SHAPE, model_shape);
        read_check(wavegen_pkg::REG_CHANNEL_SELECT, model_select);
        read_check(wavegen_pkg::REG_PERIOD, staged_period);
        read_check(wavegen_pkg::REG_AMPLITUDE, staged_amplitude);
        read_check(wavegen_pkg::REG_AUX, staged_aux);
        read_check(8'h18, '0);  // unmapped.
        read_check(8'hfc, '0);
    endtask

    task automatic set_channel(int ch, wavegen_pkg::bus_data_t period,
                               wavegen_pkg::bus_data_t amplitude,
                               wavegen_pkg::bus_data_t aux, wavegen_pkg::bus_data_t shape);
        write_reg(wavegen_pkg::REG_CHANNEL_SELECT, 32'(ch));
        write_reg(wavegen_pkg::REG_PERIOD, period);
        write_reg(wavegen_pkg::REG_AMPLITUDE, amplitude);
        write_reg(wavegen_pkg::REG_AUX, aux);
        write_reg(wavegen_pkg::REG_SHAPE, shape);
    endtask

    // one trigger pulse; the model steps only when every core is empty
    task automatic fire_trigger();
        @(posedge clock);
        #1;
        while (exp_sample.size() == 1) begin  // a lone beat may sit in core or output.
            @(posedge clock);
            #1;
        end
        trigger = 1'b1;
        if (exp_sample.size() == 0) begin
            for (int ch = 0; ch < wavegen_pkg::N_CHANNELS; ch++) begin
                if (model_count > 32'(ch)) begin
                    exp_sample.push_back(expected_sample(ch));
                    exp_channel.push_back(wavegen_pkg::channel_t'(ch));
                    exp_last.push_back(ch == wavegen_pkg::N_CHANNELS - 1 ||
                                       model_count <= 32'(ch + 1));
                    advance_phase(ch);
                end
            end
        end
        @(posedge clock);
        #1;
        trigger = 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_sample.size() != 0) begin
            @(negedge clock);
            #1;
        end
    endtask

    task automatic run_bursts(int count);
        for (int i = 0; i < count; i++) begin
            fire_trigger();
            wait_drained();
        end
    endtask

    always @(negedge clock) begin : beat_monitor
        wavegen_pkg::sample_t want_sample;
        wavegen_pkg::channel_t want_channel;
        logic want_last;
        if (!reset) begin
            if (hold_pending) begin  // stalled beat stays put.
                check_value("out_valid", 32'(out_valid), 32'd1);
                check_value("out_sample", 32'(out_sample), 32'(held_sample));
                check_value("out_channel", 32'(out_channel), 32'(held_channel));
                check_value("out_last", 32'(out_last), 32'(held_last));
            end
            if (out_valid && out_ready) begin
                if (exp_sample.size() == 0) begin
                    show_failure("an output beat appeared with no sample expected");
                    $fatal(1, "unexpected beat");
                end else begin
                    want_sample = exp_sample.pop_front();
                    want_channel = exp_channel.pop_front();
                    want_last = exp_last.pop_front();
                    check_value("out_sample", 32'(out_sample), 32'(want_sample));
                    check_value("out_channel", 32'(out_channel), 32'(want_channel));
                    check_value("out_last", 32'(out_last), 32'(want_last));
                end
            end
            hold_pending = out_valid && !out_ready;
            held_sample = out_sample;
            held_channel = out_channel;
            held_last = out_last;
        end
    end

    initial begin
        reset = 1'b1;
        trigger = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b1;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b1;
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;

        // reset state
        @(negedge clock);
        check_value("awready", 32'(awready), 32'd0);
        check_value("wready", 32'(wready), 32'd0);
        check_value("bvalid", 32'(bvalid), 32'd0);
        check_value("arready", 32'(arready), 32'd0);
        check_value("rvalid", 32'(rvalid), 32'd0);
        check_value("out_valid", 32'(out_valid), 32'd0);
        check_value("out_last", 32'(out_last), 32'd0);
        check_value("configured", 32'(configured), 32'd0);
        read_all_registers();

        // register read-back and the configured flag
        write_reg(wavegen_pkg::REG_CHANNEL_COUNT, 32'ha5a5_0003);
        write_reg(wavegen_pkg::REG_CHANNEL_SELECT, 32'hffff_fffe);  // low two bits stick.
        write_reg(wavegen_pkg::REG_PERIOD, 32'h0001_1234);
        write_reg(wavegen_pkg::REG_AMPLITUDE, 32'h0000_beef);
        write_reg(wavegen_pkg::REG_AUX, 32'h0000_0055);
        write_reg(8'h18, 32'hffff_ffff);
        @(negedge clock);
        check_value("configured", 32'(configured), 32'd0);
        read_all_registers();
        write_reg(wavegen_pkg::REG_SHAPE, 32'h6);
        @(negedge clock);
        check_value("configured", 32'(configured), 32'd1);
        read_all_registers();

        // square on four channels with code 3 on the last one
        write_reg(wavegen_pkg::REG_CHANNEL_COUNT, 32'd4);
        set_channel(0, 32'd4, 32'h1000, 32'd2, 32'd0);
        set_channel(1, 32'd5, 32'h2222, 32'd1, 32'd0);
        set_channel(2, 32'd3, 32'h7fff, 32'd3, 32'd0);
        set_channel(3, 32'd0, 32'hffff, 32'd1, 32'd3);
        read_all_registers();
        fire_trigger();
        @(negedge clock);
        check_value("out_valid", 32'(out_valid), 32'd0);
        @(negedge clock);
        check_value("out_valid", 32'(out_valid), 32'd1);  // two cycles after trigger.
        wait_drained();
        run_bursts(7);

        // triangle then sine on two channels past a full period
        random_ready = 1'b1;
        write_reg(wavegen_pkg::REG_CHANNEL_COUNT, 32'd2);
        set_channel(0, 32'd6, 32'hffff, 32'h0300, 32'd1);
        set_channel(1, 32'd70, 32'h0100, 32'h1000, 32'd1);
        run_bursts(14);
        write_reg(wavegen_pkg::REG_SHAPE, 32'd2);
        run_bursts(72);

        // backpressure with triggers landing on pending samples
        write_reg(wavegen_pkg::REG_SHAPE, 32'd0);
        write_reg(wavegen_pkg::REG_CHANNEL_COUNT, 32'd4);
        for (int i = 0; i < 60; i++) begin
            fire_trigger();
            repeat (i % 4) @(posedge clock);
        end
        wait_drained();
        random_ready = 1'b0;

        // zero channels give no output
        write_reg(wavegen_pkg::REG_CHANNEL_COUNT, 32'd0);
        repeat (5) fire_trigger();
        repeat (10) @(negedge clock);
        check_value("out_valid", 32'(out_valid), 32'd0);

        if (exp_sample.size() != 0) begin
            show_failure("expected samples never reached the output");
            $fatal(1, "missing samples");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

// File: sources.f
+incdir+include
src/wavegen_pkg.sv
src/axil_register_unit.sv
src/square_core.sv
src/triangle_core.sv
src/sine_core.sv
src/sample_serializer.sv
src/waveform_generator.sv
verif/waveform_generator_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps -f sources.f \
    --top-module waveform_generator_tb -o waveform_sim &&
{ ./obj_dir/waveform_sim | tee /dev/stderr; } | grep -q "All tests passed!" &&
echo "PASS" || { echo "FAIL"; exit 1; }
